// File: histo_macros.svh
`ifndef HISTO_MACROS_SVH
`define HISTO_MACROS_SVH

// width of a bin address
// 6 bits give 64 bins
`define HISTO_BIN_BITS 6

// width of a bin count
// counts stop at all ones
`define HISTO_COUNT_BITS 16

// width of a raw sample word
// the bin comes from the low HISTO_BIN_BITS bits
`define HISTO_SAMPLE_BITS 12

// samples taken per acquisition
`define HISTO_SAMPLE_NUM 256

`endif

// File: histoPkg.sv
`default_nettype none

`include "histo_macros.svh"

package histoPkg;

    typedef logic [`HISTO_BIN_BITS-1:0]    binAddr_t;   // bin index
    typedef logic [`HISTO_COUNT_BITS-1:0]  binCount_t;  // bin count
    typedef logic [`HISTO_SAMPLE_BITS-1:0] sample_t;    // raw sample word

    typedef enum logic [1:0] {
        idle,
        clear,
        acquire
    } ctrlState_t;

    // one RAM write port transaction
    typedef struct packed {
        logic      en;
        binAddr_t  addr;
        binCount_t data;
    } ramWrite_t;

    typedef struct packed {
        binAddr_t  index;
        binCount_t count;
    } binReport_t;

endpackage

`default_nettype wire

// File: histoRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "histo_macros.svh"

module histoRam (
    input  logic                clk,
    input  histoPkg::ramWrite_t wr,
    input  logic                rdEn,
    input  histoPkg::binAddr_t  rdAddr,
    output histoPkg::binCount_t rdData
);

    import histoPkg::*;

    // one count per bin
    binCount_t mem [0:(1 << `HISTO_BIN_BITS) - 1];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port with one cycle latency
    // a read of the address being written sees the old value
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

// File: histoCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "histo_macros.svh"

module histoCtrl (
    input  logic                clk,
    input  logic                res,
    input  logic                start,
    input  logic                sampleValid,
    input  histoPkg::sample_t   sample,
    input  histoPkg::binCount_t rdData,
    output histoPkg::ramWrite_t ramWr,
    output histoPkg::binAddr_t  ctrlRdAddr,
    output logic                ctrlRdEn,
    output logic                busy,
    output logic                acqDone
);

    import histoPkg::*;

    // wide enough to hold the full sample number
    typedef logic [$clog2(`HISTO_SAMPLE_NUM + 1) - 1:0] sampleCnt_t;

    ctrlState_t state;
    ctrlState_t nextState;

    binAddr_t   clrAddr;    // clear sweep address
    sampleCnt_t sampleCnt;  // samples accepted so far
    logic       acqLast;    // acquisition complete
    logic       accept;     // sample taken this cycle

    logic       s1Valid;    // sample waiting for its read data
    binAddr_t   s1Bin;      // bin of that sample
    ramWrite_t  lastWr;     // write of the previous cycle
    logic       fwdHit;
    binCount_t  baseCount;  // count before increment
    binCount_t  incCount;   // count after saturating increment

    assign acqLast = (sampleCnt == sampleCnt_t'(`HISTO_SAMPLE_NUM));
    assign accept  = (state == acquire) && sampleValid && !acqLast;

    // read goes out in the cycle the sample arrives
    assign ctrlRdEn   = accept;
    assign ctrlRdAddr = sample[`HISTO_BIN_BITS-1:0];

    assign busy = (state != idle);

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (start) nextState = clear;
            end
            clear: begin
                if (clrAddr == '1) nextState = acquire;  // last bin cleared
            end
            acquire: begin
                // the final write goes out in this cycle
                if (acqLast) nextState = idle;
            end
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clrAddr   <= '0;
            sampleCnt <= '0;
            acqDone   <= 1'b0;
        end else begin
            acqDone <= 1'b0;
            case (state)
                idle: begin
                    clrAddr   <= '0;  // ready for the next sweep
                    sampleCnt <= '0;
                end
                clear: begin
                    clrAddr <= clrAddr + 1'b1;
                end
                acquire: begin
                    if (accept) sampleCnt <= sampleCnt + 1'b1;
                    if (acqLast) acqDone <= 1'b1;  // lands with busy falling
                end
                default: clrAddr <= '0;
            endcase
        end
    end

    // stage 1 control and write history
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            lastWr  <= '0;
        end else begin
            s1Valid <= accept;
            lastWr  <= ramWr;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1Bin <= ctrlRdAddr;
        end
    end

    // The RAM read for this sample happened on the same edge that stored
    // the previous write, so rdData is stale when both hit one bin.
    assign fwdHit    = lastWr.en && (lastWr.addr == s1Bin);
    assign baseCount = fwdHit ? lastWr.data : rdData;
    assign incCount  = (&baseCount) ? baseCount : baseCount + 1'b1;  // saturate

    always_comb begin
        ramWr = '0;
        if (state == clear) begin
            ramWr.en   = 1'b1;  // data stays zero
            ramWr.addr = clrAddr;
        end else if (s1Valid) begin
            ramWr.en   = 1'b1;
            ramWr.addr = s1Bin;
            ramWr.data = incCount;
        end
    end

endmodule

`default_nettype wire

// File: histoReadout.sv
`timescale 1ns/1ps
`default_nettype none

module histoReadout (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 dumpStart,
    input  logic                 busy,
    input  logic                 ctrlRdEn,
    input  histoPkg::binAddr_t   ctrlRdAddr,
    input  histoPkg::binCount_t  rdData,
    output histoPkg::binAddr_t   rdAddr,
    output logic                 rdEn,
    output logic                 reportValid,
    output histoPkg::binReport_t report,
    output logic                 dumpDone
);

    import histoPkg::*;

    logic     dumping;   // sweep in progress
    binAddr_t dumpAddr;  // next bin to read
    binAddr_t repIndex;  // index of the count now on rdData

    // the dump owns the read port while it runs
    assign rdAddr = dumping ? dumpAddr : ctrlRdAddr;
    assign rdEn   = dumping ? 1'b1 : ctrlRdEn;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dumping  <= 1'b0;
            dumpAddr <= '0;
        end else if (dumping) begin
            dumpAddr <= dumpAddr + 1'b1;
            if (dumpAddr == '1) dumping <= 1'b0;  // last bin read
        end else if (dumpStart && !busy) begin
            dumping  <= 1'b1;
            dumpAddr <= '0;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            reportValid <= 1'b0;
            dumpDone    <= 1'b0;
        end else begin
            reportValid <= dumping;  // follows the read latency
            dumpDone    <= reportValid && (repIndex == '1);
        end
    end

    // index travels one cycle behind its read
    always_ff @(posedge clk) begin
        if (dumping) begin
            repIndex <= dumpAddr;
        end
    end

    assign report = '{index: repIndex, count: rdData};

endmodule

`default_nettype wire

// File: histoTop.sv
`timescale 1ns/1ps
`default_nettype none

module histoTop (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 start,
    input  logic                 sampleValid,
    input  logic                 dumpStart,
    input  histoPkg::sample_t    sample,
    output logic                 busy,
    output logic                 acqDone,
    output logic                 reportValid,
    output logic                 dumpDone,
    output histoPkg::binReport_t report
);

    import histoPkg::*;

    ramWrite_t ramWr;       // controller write port
    binAddr_t  ctrlRdAddr;  // controller read request
    logic      ctrlRdEn;
    binAddr_t  rdAddr;      // read port after the dump mux
    logic      rdEn;
    binCount_t rdData;

    histoCtrl histoCtrl_i (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .sampleValid (sampleValid),
        .sample      (sample),
        .rdData      (rdData),
        .ramWr       (ramWr),
        .ctrlRdAddr  (ctrlRdAddr),
        .ctrlRdEn    (ctrlRdEn),
        .busy        (busy),
        .acqDone     (acqDone)
    );

    histoReadout histoReadout_i (
        .clk         (clk),
        .res         (res),
        .dumpStart   (dumpStart),
        .busy        (busy),
        .ctrlRdEn    (ctrlRdEn),
        .ctrlRdAddr  (ctrlRdAddr),
        .rdData      (rdData),
        .rdAddr      (rdAddr),
        .rdEn        (rdEn),
        .reportValid (reportValid),
        .report      (report),
        .dumpDone    (dumpDone)
    );

    histoRam histoRam_i (
        .clk    (clk),
        .wr     (ramWr),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

endmodule

`default_nettype wire

// File: tbHisto.sv
`timescale 1ns/1ps
`default_nettype none

`include "histo_macros.svh"

module tbHisto;

    import histoPkg::*;

    localparam int binNum   = 1 << `HISTO_BIN_BITS;
    localparam int countMax = (1 << `HISTO_COUNT_BITS) - 1;
    localparam int maxGap   = 3;  // idle cycles between strobes in the gap test
    // reset, five rounds of clear, samples, drain and dump, the gaps of one test, margin
    localparam int timeoutCycles = 2 * (10 + 5 * (66 + `HISTO_SAMPLE_NUM + 4 + 70)
                                        + `HISTO_SAMPLE_NUM * maxGap + 20);

    logic       clk;
    logic       res;
    logic       start, sampleValid, dumpStart;
    sample_t    sample;
    logic       busy, acqDone, reportValid, dumpDone;
    binReport_t report;

    int model [binNum];  // expected count per bin
    int errors   = 0;
    int checks   = 0;
    int cycleCnt = 0;

    histoTop histoTop_i (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .sampleValid (sampleValid),
        .dumpStart   (dumpStart),
        .sample      (sample),
        .busy        (busy),
        .acqDone     (acqDone),
        .reportValid (reportValid),
        .dumpDone    (dumpDone),
        .report      (report)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= timeoutCycles) begin
            $display("run did not finish within %0d cycles", timeoutCycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic checkFlag(input string testName, input string flagName,
                             input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s %s: expected %0b, actual %0b",
                     testName, flagName, expected, actual);
        end
    endtask

    task automatic checkReport(input string testName, input binReport_t expected,
                               input binReport_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s report: expected bin %0d count %0d, actual bin %0d count %0d",
                     testName, expected.index, expected.count, actual.index, actual.count);
        end
    endtask

    task automatic countSample(input sample_t s);
        int bin;
        bin = int'(s[`HISTO_BIN_BITS-1:0]);  // low bits pick the bin
        if (model[bin] < countMax) model[bin]++;
    endtask

    task automatic strayStrobes(input int cycles);
        repeat (cycles) begin
            sampleValid = 1'b1;
            sample      = sample_t'($urandom);
            @(negedge clk);
        end
        sampleValid = 1'b0;
    endtask

    task automatic startAcq(input string testName, input bit strobeInClear,
                            input bit dumpInClear);
        ctrlState_t st;
        foreach (model[i]) model[i] = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int i = 0; i < binNum; i++) begin  // one cycle per cleared bin
            checkFlag(testName, "busy in clear", 1'b1, busy);
            checkFlag(testName, "reportValid in clear", 1'b0, reportValid);
            sampleValid = strobeInClear;
            sample      = sample_t'($urandom);
            dumpStart   = dumpInClear && (i == 10);  // must be ignored
            @(negedge clk);
        end
        sampleValid = 1'b0;
        dumpStart   = 1'b0;
        st = histoTop_i.histoCtrl_i.state;
        checks++;
        if (st !== acquire) begin
            errors++;
            $display("Mismatch %s state after clear: expected acquire, actual %s (%b)",
                     testName, st.name(), st);
        end
    endtask

    task automatic sendSamples(input string testName, input sample_t samples[$],
                               input int gapMax);
        int gap;
        foreach (samples[i]) begin
            checkFlag(testName, "busy in acquire", 1'b1, busy);
            sampleValid = 1'b1;
            sample      = samples[i];
            countSample(samples[i]);
            @(negedge clk);
            sampleValid = 1'b0;
            gap = (i < samples.size() - 1) ? int'($urandom_range(gapMax, 0)) : 0;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic waitAcqDone(input string testName);
        int n;
        n = 0;
        while (!acqDone && n < 8) begin
            checkFlag(testName, "busy before acqDone", 1'b1, busy);
            @(negedge clk);
            n++;
        end
        checks++;
        if (!acqDone) begin
            errors++;
            $display("%s: acqDone did not pulse after the last sample", testName);
        end else if (n != 1) begin
            errors++;
            $display("%s: acqDone came %0d cycles after the last sample, not 2",
                     testName, n + 1);
        end
        checkFlag(testName, "busy at acqDone", 1'b0, busy);
        @(negedge clk);
        checkFlag(testName, "acqDone after its pulse", 1'b0, acqDone);
    endtask

    task automatic runDump(input string testName);
        binReport_t expected;
        int n;
        checkFlag(testName, "busy before dump", 1'b0, busy);
        dumpStart = 1'b1;
        @(negedge clk);
        dumpStart = 1'b0;
        n = 1;
        while (!reportValid && n < 8) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (!reportValid) begin
            errors++;
            $display("%s: no report followed dumpStart", testName);
        end else if (n != 2) begin
            errors++;
            $display("%s: first report came %0d cycles after dumpStart, not 2", testName, n);
        end
        for (int i = 0; i < binNum; i++) begin  // reports in address order
            expected.index = binAddr_t'(i);
            expected.count = binCount_t'(model[i]);
            checkFlag(testName, "reportValid", 1'b1, reportValid);
            checkFlag(testName, "dumpDone during dump", 1'b0, dumpDone);
            checkReport(testName, expected, report);
            @(negedge clk);
        end
        checkFlag(testName, "dumpDone after last report", 1'b1, dumpDone);
        checkFlag(testName, "reportValid after last report", 1'b0, reportValid);
        @(negedge clk);
        checkFlag(testName, "dumpDone after its pulse", 1'b0, dumpDone);
    endtask

    task automatic acquireAndDump(input string testName, input sample_t samples[$],
                                  input int gapMax, input bit strays, input bit dumpInClear);
        if (strays) strayStrobes(6);  // idle, nothing counted
        startAcq(testName, strays, dumpInClear);
        sendSamples(testName, samples, gapMax);
        waitAcqDone(testName);
        if (strays) strayStrobes(6);
        runDump(testName);
    endtask

    task automatic endTest(input string testName, input int errorsBefore);
        $display("%s: %s, %0d errors", testName,
                 (errors == errorsBefore) ? "passed" : "failed", errors - errorsBefore);
    endtask

    // mode 0 one bin, 1 random, 2 upper bins only, 3 short repeat pattern
    task automatic buildSamples(input int mode, output sample_t samples[$]);
        sample_t s;
        int      pat [8];
        pat = '{9, 9, 12, 9, 12, 12, 9, 17};  // hits one and two samples apart
        samples = {};
        for (int i = 0; i < `HISTO_SAMPLE_NUM; i++) begin
            s = sample_t'($urandom);
            if (mode == 0) s[`HISTO_BIN_BITS-1:0] = binAddr_t'(5);
            if (mode == 2) s[`HISTO_BIN_BITS-1:`HISTO_BIN_BITS-2] = 2'b10;
            if (mode == 3) s[`HISTO_BIN_BITS-1:0] = binAddr_t'(pat[i % 8]);
            samples.push_back(s);
        end
    endtask

    task automatic runTest(input string testName, input int mode, input int gapMax,
                           input bit strays, input bit dumpInClear);
        int      errBefore;
        sample_t samples[$];
        errBefore = errors;
        buildSamples(mode, samples);
        acquireAndDump(testName, samples, gapMax, strays, dumpInClear);
        endTest(testName, errBefore);
    endtask

    initial begin
        res         = 1'b0;
        start       = 1'b0;
        sampleValid = 1'b0;
        dumpStart   = 1'b0;
        sample      = '0;
        void'($urandom(79));
        repeat (10) @(negedge clk);
        res = 1'b1;
        checkFlag("reset", "busy", 1'b0, busy);
        checkFlag("reset", "acqDone", 1'b0, acqDone);
        checkFlag("reset", "reportValid", 1'b0, reportValid);
        checkFlag("reset", "dumpDone", 1'b0, dumpDone);
        @(negedge clk);
        runTest("singleBin", 0, 0, 1'b0, 1'b0);
        runTest("randomBins", 1, 0, 1'b0, 1'b0);
        runTest("gapsAndStrays", 1, maxGap, 1'b1, 1'b0);
        runTest("reacquire", 2, 0, 1'b0, 1'b1);
        runTest("pulseTiming", 3, 0, 1'b0, 1'b0);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: histoTop.f
+incdir+.
histoPkg.sv
histoRam.sv
histoCtrl.sv
histoReadout.sv
histoTop.sv
tbHisto.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f histoTop.f --top-module tbHisto -o tbHisto
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tbHisto > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
